// ==== src/rv_pkg.sv ====
package rv_pkg;

  parameter int XLEN       = 32;
  parameter int REG_ADDR_W = 5;

  // RV32I major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    opc_load   = 7'b000_0011,
    opc_op_imm = 7'b001_0011,
    opc_auipc  = 7'b001_0111,
    opc_store  = 7'b010_0011,
    opc_op     = 7'b011_0011,
    opc_lui    = 7'b011_0111,
    opc_branch = 7'b110_0011,
    opc_jalr   = 7'b110_0111,
    opc_jal    = 7'b110_1111,
    opc_system = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    kind_alu_reg,
    kind_alu_imm,
    kind_load,
    kind_store,
    kind_branch,
    kind_jal,
    kind_jalr,
    kind_lui,
    kind_auipc,
    kind_system,   // ebreak only
    kind_illegal
  } op_kind_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_link
  } wb_src_e;

  // funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

endpackage

// ==== src/rv_ctrl_fsm.sv ====
`timescale 1ns/1ps

module rv_ctrl_fsm (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::op_kind_e op_kind,
  input  logic             wb_ack,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output logic             data_phase,
  output logic             inst_load,
  output logic             pc_load,
  output logic             rf_wen,
  input  logic             rd_write,
  output logic             halted
);

  typedef enum logic [1:0] {
    st_fetch,
    st_execute,
    st_mem,
    st_halt
  } state_e;

  state_e state;
  logic   stb_q;       // cyc and stb share one flop
  logic   is_mem;
  logic   retire_exec;
  logic   retire_mem;

  assign is_mem      = (op_kind == rv_pkg::kind_load) || (op_kind == rv_pkg::kind_store);
  assign retire_exec = (state == st_execute) && !is_mem && (op_kind != rv_pkg::kind_system);
  assign retire_mem  = (state == st_mem) && stb_q && wb_ack;

  assign wb_cyc     = stb_q;
  assign wb_stb     = stb_q;
  assign data_phase = (state == st_mem);
  assign wb_we      = stb_q && data_phase && (op_kind == rv_pkg::kind_store);
  assign inst_load  = (state == st_fetch) && stb_q && wb_ack;  // latch fetched word
  assign pc_load    = retire_exec || retire_mem;
  assign rf_wen     = pc_load && rd_write;
  assign halted     = (state == st_halt);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_fetch;
      stb_q <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          if (!stb_q) begin
            stb_q <= 1'b1;  // first fetch out of reset
          end else if (wb_ack) begin
            stb_q <= 1'b0;
            state <= st_execute;
          end
        end
        st_execute: begin
          if (op_kind == rv_pkg::kind_system) begin
            state <= st_halt;  // ebreak
          end else if (is_mem) begin
            state <= st_mem;
            stb_q <= 1'b1;
          end else begin
            state <= st_fetch;
            stb_q <= 1'b1;
          end
        end
        st_mem: begin
          // strobe stays up, next access is the fetch at the new pc
          if (wb_ack) begin
            state <= st_fetch;
          end
        end
        default: begin
          stb_q <= 1'b0;  // halt is terminal
        end
      endcase
    end
  end

  a_stb_in_bus_state: assert property (@(posedge clk) disable iff (rst)
    wb_stb |-> (state == st_fetch || state == st_mem));

  a_quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
    halted |=> (halted && !wb_stb));

endmodule

// ==== src/rv_pc_counter.sv ====
`timescale 1ns/1ps

module rv_pc_counter #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    pc_load,
  input  rv_pkg::op_kind_e        op_kind,
  input  logic                    branch_taken,
  input  logic [rv_pkg::XLEN-1:0] imm,
  input  logic [rv_pkg::XLEN-1:0] alu_result,
  output logic [rv_pkg::XLEN-1:0] pc,
  output logic [rv_pkg::XLEN-1:0] pc_link
);

  logic [rv_pkg::XLEN-1:0] pc_target;
  logic [rv_pkg::XLEN-1:0] pc_next;

  assign pc_link   = pc + 32'd4;
  assign pc_target = pc + imm;  // jal and branch offsets

  always_comb begin
    case (op_kind)
      rv_pkg::kind_jal:    pc_next = pc_target;
      rv_pkg::kind_branch: pc_next = branch_taken ? pc_target : pc_link;
      rv_pkg::kind_jalr:   pc_next = {alu_result[rv_pkg::XLEN-1:1], 1'b0};
      default:             pc_next = pc_link;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (pc_load) begin
      pc <= pc_next;
    end
  end

  // no compressed set, so every target must be a word address
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// ==== src/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  logic                          clk,
  input  logic                          inst_load,
  input  logic [rv_pkg::XLEN-1:0]       inst_in,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2,
  output logic [rv_pkg::REG_ADDR_W-1:0] rd,
  output logic [2:0]                    funct3,
  output logic [rv_pkg::XLEN-1:0]       imm,
  output rv_pkg::op_kind_e              op_kind,
  output rv_pkg::alu_op_e               alu_op,
  output rv_pkg::wb_src_e               wb_src,
  output logic                          rd_write
);

  logic [rv_pkg::XLEN-1:0] inst;
  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] imm_s;
  logic [rv_pkg::XLEN-1:0] imm_b;
  logic [rv_pkg::XLEN-1:0] imm_u;
  logic [rv_pkg::XLEN-1:0] imm_j;
  logic                    is_ebreak;
  rv_pkg::alu_op_e         arith_op;

  always_ff @(posedge clk) begin
    if (inst_load) begin
      inst <= inst_in;
    end
  end

  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign is_ebreak = (inst[31:20] == 12'h001) && (inst[19:7] == 13'h0000);

  always_comb begin
    case (rv_pkg::opcode_e'(inst[6:0]))
      rv_pkg::opc_op:     op_kind = rv_pkg::kind_alu_reg;
      rv_pkg::opc_op_imm: op_kind = rv_pkg::kind_alu_imm;
      rv_pkg::opc_load:   op_kind = rv_pkg::kind_load;
      rv_pkg::opc_store:  op_kind = rv_pkg::kind_store;
      rv_pkg::opc_branch: op_kind = rv_pkg::kind_branch;
      rv_pkg::opc_jal:    op_kind = rv_pkg::kind_jal;
      rv_pkg::opc_jalr:   op_kind = rv_pkg::kind_jalr;
      rv_pkg::opc_lui:    op_kind = rv_pkg::kind_lui;
      rv_pkg::opc_auipc:  op_kind = rv_pkg::kind_auipc;
      // ecall and csr fall through as plain pc advance
      rv_pkg::opc_system: op_kind = is_ebreak ? rv_pkg::kind_system : rv_pkg::kind_illegal;
      default:            op_kind = rv_pkg::kind_illegal;
    endcase
  end

  always_comb begin
    case (op_kind)
      // slli/srli/srai use only imm[4:0] as shamt
      rv_pkg::kind_alu_imm, rv_pkg::kind_load, rv_pkg::kind_jalr: imm = imm_i;
      rv_pkg::kind_store:                   imm = imm_s;
      rv_pkg::kind_branch:                  imm = imm_b;
      rv_pkg::kind_lui, rv_pkg::kind_auipc: imm = imm_u;
      rv_pkg::kind_jal:                     imm = imm_j;
      default:                              imm = '0;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  arith_op = (op_kind == rv_pkg::kind_alu_reg && inst[30]) ? rv_pkg::alu_sub
                                                                        : rv_pkg::alu_add;
      3'b001:  arith_op = rv_pkg::alu_sll;
      3'b010:  arith_op = rv_pkg::alu_slt;
      3'b011:  arith_op = rv_pkg::alu_sltu;
      3'b100:  arith_op = rv_pkg::alu_xor;
      3'b101:  arith_op = inst[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  arith_op = rv_pkg::alu_or;
      default: arith_op = rv_pkg::alu_and;
    endcase
    case (op_kind)
      rv_pkg::kind_alu_reg, rv_pkg::kind_alu_imm: alu_op = arith_op;
      rv_pkg::kind_lui:                           alu_op = rv_pkg::alu_pass_b;
      rv_pkg::kind_branch:                        alu_op = rv_pkg::alu_sub;  // compare
      default:                                    alu_op = rv_pkg::alu_add;  // address math
    endcase
  end

  always_comb begin
    case (op_kind)
      rv_pkg::kind_load:                  wb_src = rv_pkg::wb_load;
      rv_pkg::kind_jal, rv_pkg::kind_jalr: wb_src = rv_pkg::wb_link;
      default:                            wb_src = rv_pkg::wb_alu;
    endcase
  end

  assign rd_write = op_kind inside {rv_pkg::kind_alu_reg, rv_pkg::kind_alu_imm,
                                    rv_pkg::kind_load, rv_pkg::kind_jal, rv_pkg::kind_jalr,
                                    rv_pkg::kind_lui, rv_pkg::kind_auipc};

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          rf_wen,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
  input  rv_pkg::wb_src_e               wb_src,
  input  logic [rv_pkg::XLEN-1:0]       alu_result,
  input  logic [rv_pkg::XLEN-1:0]       load_data,
  input  logic [rv_pkg::XLEN-1:0]       pc_link,
  output logic [rv_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_pkg::XLEN-1:0]       rs2_data
);

  logic [rv_pkg::XLEN-1:0] regs [0:(1 << rv_pkg::REG_ADDR_W)-1];
  logic [rv_pkg::XLEN-1:0] wr_data;

  always_comb begin
    case (wb_src)
      rv_pkg::wb_load: wr_data = load_data;
      rv_pkg::wb_link: wr_data = pc_link;  // jal/jalr return address
      default:         wr_data = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rf_wen && rd != '0) begin
      regs[rd] <= wr_data;
    end
  end

  // x0 reads as zero, entry 0 is never written
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::op_kind_e        op_kind,
  input  rv_pkg::alu_op_e         alu_op,
  input  logic [2:0]              funct3,
  input  logic [rv_pkg::XLEN-1:0] rs1_data,
  input  logic [rv_pkg::XLEN-1:0] rs2_data,
  input  logic [rv_pkg::XLEN-1:0] imm,
  input  logic [rv_pkg::XLEN-1:0] pc,
  output logic [rv_pkg::XLEN-1:0] alu_result,
  output logic                    branch_taken
);

  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] sum;
  logic [rv_pkg::XLEN-1:0] diff;
  logic [4:0]              shamt;
  logic                    carry;  // no borrow when set, a >= b unsigned
  logic                    eq;
  logic                    lt;
  logic                    ltu;

  assign op_a  = (op_kind == rv_pkg::kind_auipc) ? pc : rs1_data;
  assign op_b  = (op_kind == rv_pkg::kind_alu_reg || op_kind == rv_pkg::kind_branch) ?
                 rs2_data : imm;
  assign shamt = op_b[4:0];

  assign sum           = op_a + op_b;
  assign {carry, diff} = {1'b0, op_a} + {1'b0, ~op_b} + 33'd1;

  // one compare serves slt/sltu and all six branches
  assign eq  = (diff == '0);
  assign ltu = !carry;
  assign lt  = (op_a[rv_pkg::XLEN-1] != op_b[rv_pkg::XLEN-1]) ? op_a[rv_pkg::XLEN-1]
                                                              : diff[rv_pkg::XLEN-1];

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:    alu_result = sum;
      rv_pkg::alu_sub:    alu_result = diff;
      rv_pkg::alu_sll:    alu_result = op_a << shamt;
      rv_pkg::alu_slt:    alu_result = {{(rv_pkg::XLEN-1){1'b0}}, lt};
      rv_pkg::alu_sltu:   alu_result = {{(rv_pkg::XLEN-1){1'b0}}, ltu};
      rv_pkg::alu_xor:    alu_result = op_a ^ op_b;
      rv_pkg::alu_srl:    alu_result = op_a >> shamt;
      rv_pkg::alu_sra:    alu_result = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::alu_or:     alu_result = op_a | op_b;
      rv_pkg::alu_and:    alu_result = op_a & op_b;
      default:            alu_result = op_b;  // lui
    endcase
  end

  always_comb begin
    branch_taken = 1'b0;
    if (op_kind == rv_pkg::kind_branch) begin
      case (funct3)
        3'b000:  branch_taken = eq;
        3'b001:  branch_taken = !eq;
        3'b100:  branch_taken = lt;
        3'b101:  branch_taken = !lt;
        3'b110:  branch_taken = ltu;
        3'b111:  branch_taken = !ltu;
        default: branch_taken = 1'b0;
      endcase
    end
  end

endmodule

// ==== src/rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu (
  input  logic [2:0]              funct3,
  input  logic [1:0]              addr_low,
  input  logic [rv_pkg::XLEN-1:0] rs2_data,
  input  logic [rv_pkg::XLEN-1:0] wb_rdata,
  output logic [3:0]              wb_sel,
  output logic [rv_pkg::XLEN-1:0] wb_wdata,
  output logic [rv_pkg::XLEN-1:0] load_data
);

  rv_pkg::mem_size_e       size;
  logic                    unsigned_ld;  // lbu/lhu
  logic [rv_pkg::XLEN-1:0] lane;

  assign size        = rv_pkg::mem_size_e'(funct3[1:0]);
  assign unsigned_ld = funct3[2];
  assign lane        = wb_rdata >> {addr_low, 3'b000};  // addressed lane down to bit 0

  always_comb begin
    case (size)
      rv_pkg::size_byte: begin
        wb_wdata  = {4{rs2_data[7:0]}};
        wb_sel    = 4'b0001 << addr_low;
        load_data = unsigned_ld ? {24'd0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
      end
      rv_pkg::size_half: begin
        wb_wdata  = {2{rs2_data[15:0]}};
        wb_sel    = addr_low[1] ? 4'b1100 : 4'b0011;
        load_data = unsigned_ld ? {16'd0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
      end
      default: begin
        wb_wdata  = rs2_data;  // full word
        wb_sel    = 4'b1111;
        load_data = wb_rdata;
      end
    endcase
  end

endmodule

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic                    clk,
  input  logic                    rst,
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output logic                    wb_we,
  output logic [rv_pkg::XLEN-1:0] wb_adr,
  output logic [rv_pkg::XLEN-1:0] wb_wdata,
  output logic [3:0]              wb_sel,
  input  logic                    wb_ack,
  input  logic [rv_pkg::XLEN-1:0] wb_rdata,
  output logic                    halted
);

  logic                          data_phase;
  logic                          inst_load;
  logic                          pc_load;
  logic                          rf_wen;
  logic                          rd_write;
  logic                          branch_taken;
  rv_pkg::op_kind_e              op_kind;
  rv_pkg::alu_op_e               alu_op;
  rv_pkg::wb_src_e               wb_src;
  logic [2:0]                    funct3;
  logic [rv_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_pkg::REG_ADDR_W-1:0] rd;
  logic [rv_pkg::XLEN-1:0]       imm;
  logic [rv_pkg::XLEN-1:0]       rs1_data;
  logic [rv_pkg::XLEN-1:0]       rs2_data;
  logic [rv_pkg::XLEN-1:0]       alu_result;
  logic [rv_pkg::XLEN-1:0]       load_data;
  logic [rv_pkg::XLEN-1:0]       pc;
  logic [rv_pkg::XLEN-1:0]       pc_link;
  logic [3:0]                    lsu_sel;
  rv_pkg::mem_size_e             mem_size;

  assign wb_adr   = data_phase ? alu_result : pc;  // data access or fetch
  assign wb_sel   = data_phase ? lsu_sel : 4'b1111;  // fetches read the whole word
  assign mem_size = rv_pkg::mem_size_e'(funct3[1:0]);

  rv_ctrl_fsm u_fsm (
    .clk(clk), .rst(rst), .op_kind(op_kind), .wb_ack(wb_ack),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .data_phase(data_phase),
    .inst_load(inst_load), .pc_load(pc_load), .rf_wen(rf_wen),
    .rd_write(rd_write), .halted(halted)
  );

  rv_pc_counter #(.RESET_PC(RESET_PC)) u_pc (
    .clk(clk), .rst(rst), .pc_load(pc_load), .op_kind(op_kind),
    .branch_taken(branch_taken), .imm(imm), .alu_result(alu_result),
    .pc(pc), .pc_link(pc_link)
  );

  rv_decoder u_dec (
    .clk(clk), .inst_load(inst_load), .inst_in(wb_rdata),
    .rs1(rs1), .rs2(rs2), .rd(rd), .funct3(funct3), .imm(imm),
    .op_kind(op_kind), .alu_op(alu_op), .wb_src(wb_src), .rd_write(rd_write)
  );

  rv_regfile u_rf (
    .clk(clk), .rf_wen(rf_wen), .rs1(rs1), .rs2(rs2), .rd(rd),
    .wb_src(wb_src), .alu_result(alu_result), .load_data(load_data),
    .pc_link(pc_link), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_alu u_alu (
    .op_kind(op_kind), .alu_op(alu_op), .funct3(funct3),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc),
    .alu_result(alu_result), .branch_taken(branch_taken)
  );

  rv_lsu u_lsu (
    .funct3(funct3), .addr_low(alu_result[1:0]), .rs2_data(rs2_data),
    .wb_rdata(wb_rdata), .wb_sel(lsu_sel), .wb_wdata(wb_wdata), .load_data(load_data)
  );

  // the LSU has no split path for unaligned data
  a_mem_aligned: assert property (@(posedge clk) disable iff (rst)
    (data_phase && wb_stb) |->
      !((mem_size == rv_pkg::size_half && alu_result[0]) ||
        (mem_size == rv_pkg::size_word && alu_result[1:0] != 2'b00)));

endmodule

// ==== dv/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

  localparam logic [31:0] RESET_PC   = 32'h8000_0000;
  localparam logic [31:0] LCG_SEED   = 32'h041ff217;
  localparam int          RST_CYCLES = 8;
  localparam int          HALT_WATCH = 20;  // quiet cycles checked after halt

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_wdata;
  logic [3:0]  wb_sel;
  logic        wb_ack;
  logic [31:0] wb_rdata;
  logic        halted;

  logic [31:0] mem [logic [31:0]];  // sparse memory keyed by word address
  logic [31:0] exp_adr [$];
  logic [31:0] exp_data [$];
  logic [3:0]  exp_sel [$];

  int          num_words;
  int          cycle_limit;
  int          cycles;
  int          wait_left;
  bit          busy;
  bit          first_fetch_seen;
  bit          halt_seen;
  logic [31:0] rand_state;

  // bus values of the previous cycle
  logic        held_stb;
  logic        held_ack;
  logic        held_rst;
  logic        held_we;
  logic [31:0] held_adr;
  logic [31:0] held_wdata;
  logic [3:0]  held_sel;

  rv_core_top #(.RESET_PC(RESET_PC)) u_dut (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_sel(wb_sel), .wb_ack(wb_ack),
    .wb_rdata(wb_rdata), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // unmapped words read back as a pattern of their address
  function automatic logic [31:0] read_word(input logic [31:0] adr);
    logic [31:0] key;
    key = adr >> 2;
    if (mem.exists(key)) begin
      return mem[key];
    end
    return {adr[15:0], ~adr[31:16]};
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      stop_with_error($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic load_vectors();
    int                 fd;
    int                 n;
    byte                tag;
    logic [31:0]        a;
    logic [31:0]        d;
    logic [3:0]         s;
    logic [8*200-1:0]   line;
    fd = $fopen("dv/core_vectors.txt", "r");
    if (fd == 0) begin
      stop_with_error("cannot open dv/core_vectors.txt");
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", tag);
      if (n != 1) break;
      if (tag == "#") begin
        n = $fgets(line, fd);  // comment line
      end else if (tag == "P") begin
        n = $fscanf(fd, "%h %h", a, d);
        mem[a >> 2] = d;
        num_words++;
      end else if (tag == "S") begin
        n = $fscanf(fd, "%h %h %h", a, d, s);
        exp_adr.push_back(a);
        exp_data.push_back(d);
        exp_sel.push_back(s);
      end else begin
        stop_with_error($sformatf("unknown tag %c in the vectors file", tag));
      end
    end
    $fclose(fd);
  endtask

  task automatic check_store();
    if (exp_adr.size() == 0) begin
      stop_with_error($sformatf("unexpected store to %h at %0t", wb_adr, $time));
    end
    check_word("wb_adr", wb_adr, exp_adr.pop_front());
    check_word("wb_wdata", wb_wdata, exp_data.pop_front());
    check_word("wb_sel", {28'd0, wb_sel}, {28'd0, exp_sel.pop_front()});
  endtask

  task automatic write_word();
    logic [31:0] w;
    w = read_word(wb_adr);
    for (int i = 0; i < 4; i++) begin
      if (wb_sel[i]) w[8*i +: 8] = wb_wdata[8*i +: 8];
    end
    mem[wb_adr >> 2] = w;
  endtask

  // memory slave with a registered ack after 0 to 3 wait cycles
  always @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      busy = 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;  // access ended at this edge
    end else if (wb_stb) begin
      if (!busy) begin
        busy = 1'b1;
        rand_state = lcg_next(rand_state);
        wait_left = int'(rand_state[17:16]);
      end
      if (wait_left == 0) begin
        busy = 1'b0;
        wb_ack <= 1'b1;
        if (wb_we) begin
          check_store();
          write_word();
        end else begin
          wb_rdata <= read_word(wb_adr);
        end
      end else begin
        wait_left--;
      end
    end
  end

  // bus protocol monitor
  always @(posedge clk) begin
    if (rst && held_rst) begin
      check_word("wb_stb", {31'd0, wb_stb}, 32'd0);
      check_word("wb_cyc", {31'd0, wb_cyc}, 32'd0);
      check_word("halted", {31'd0, halted}, 32'd0);
    end else if (!rst) begin
      if (held_rst) begin
        check_word("wb_stb", {31'd0, wb_stb}, 32'd0);  // first cycle after reset
        check_word("halted", {31'd0, halted}, 32'd0);
      end
      check_word("wb_cyc", {31'd0, wb_cyc}, {31'd0, wb_stb});
      if (wb_stb && !first_fetch_seen) begin
        first_fetch_seen = 1'b1;
        check_word("wb_adr", wb_adr, RESET_PC);
        check_word("wb_we", {31'd0, wb_we}, 32'd0);
        check_word("wb_sel", {28'd0, wb_sel}, 32'h0000_000f);
      end
      if (held_stb && !held_ack) begin  // waiting access must hold still
        check_word("wb_stb", {31'd0, wb_stb}, 32'd1);
        check_word("wb_adr", wb_adr, held_adr);
        check_word("wb_we", {31'd0, wb_we}, {31'd0, held_we});
        check_word("wb_sel", {28'd0, wb_sel}, {28'd0, held_sel});
        check_word("wb_wdata", wb_wdata, held_wdata);
      end
      if (halt_seen) begin
        check_word("halted", {31'd0, halted}, 32'd1);
        check_word("wb_stb", {31'd0, wb_stb}, 32'd0);
      end
      if (halted === 1'b1) halt_seen = 1'b1;
    end
    held_rst   <= rst;
    held_stb   <= wb_stb;
    held_ack   <= wb_ack;
    held_we    <= wb_we;
    held_adr   <= wb_adr;
    held_sel   <= wb_sel;
    held_wdata <= wb_wdata;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      stop_with_error($sformatf("timeout, core did not halt within %0d cycles", cycle_limit));
    end
  end

  initial begin
    rst        = 1'b1;
    wb_ack     = 1'b0;
    wb_rdata   = '0;
    rand_state = LCG_SEED;
    held_rst   = 1'b0;
    held_stb   = 1'b0;
    held_ack   = 1'b0;
    load_vectors();
    cycle_limit = 16 * num_words + 200;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    while (halted !== 1'b1) @(posedge clk);
    assert (exp_adr.size() == 0) else begin
      stop_with_error($sformatf("core halted with %0d expected stores missing",
                                exp_adr.size()));
    end
    repeat (HALT_WATCH) @(posedge clk);
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== dv/core_vectors.txt ====
# P <word address in hex> <instruction word>
# S <store address> <store data> <byte selects>, in program order
# alu ops, x1 = 80001000, x2 = -7, x3 = 5
P 80000000 800010B7
P 80000004 FF900113
P 80000008 00500193
P 8000000C 00310233
P 80000010 0040A023
P 80000014 40310233
P 80000018 0040A223
P 8000001C 00314233
P 80000020 0040A423
P 80000024 00316233
P 80000028 0040A623
P 8000002C 00317233
P 80000030 0040A823
P 80000034 00311233
P 80000038 0040AA23
P 8000003C 00315233
P 80000040 0040AC23
P 80000044 40315233
P 80000048 0040AE23
P 8000004C 00312233
P 80000050 0240A023
P 80000054 00313233
P 80000058 0240A223
P 8000005C 40115213
P 80000060 0240A423
P 80000064 00001217
P 80000068 0240A623
# load source word 80FF7F01 at 80001030
P 8000006C 80FF82B7
P 80000070 F0128293
P 80000074 0250A823
P 80000078 03008303
P 8000007C 046080A3
P 80000080 03108303
P 80000084 04609223
P 80000088 03208303
P 8000008C 04608023
P 80000090 03308303
P 80000094 0460A423
P 80000098 046081A3
P 8000009C 0320C303
P 800000A0 0460A623
P 800000A4 0330C303
P 800000A8 04608123
P 800000AC 03009303
P 800000B0 04609323
P 800000B4 03209303
P 800000B8 0460A823
P 800000BC 0320D303
P 800000C0 0460AA23
P 800000C4 0300A303
P 800000C8 0460AC23
# branches, taken ones skip a store to 80001100
P 800000CC 00310463
P 800000D0 0630A023
P 800000D4 00311463
P 800000D8 1000A023
P 800000DC 00314463
P 800000E0 1000A023
P 800000E4 00315463
P 800000E8 0630A223
P 800000EC 00316463
P 800000F0 0630A423
P 800000F4 00317463
P 800000F8 1000A023
P 800000FC 00318463
P 80000100 1000A023
P 80000104 00319463
P 80000108 0630A623
P 8000010C 0021C463
P 80000110 0630A823
P 80000114 0021D463
P 80000118 1000A023
P 8000011C 0021E463
P 80000120 1000A023
P 80000124 0021F463
P 80000128 0630AA23
# jal, jalr, then ebreak
P 8000012C 00C0046F
P 80000130 1000A023
P 80000134 1000A023
P 80000138 0680AC23
P 8000013C 018404E7
P 80000140 1000A023
P 80000144 1000A023
P 80000148 0690AE23
P 8000014C 00100073
S 80001000 FFFFFFFE F
S 80001004 FFFFFFF4 F
S 80001008 FFFFFFFC F
S 8000100C FFFFFFFD F
S 80001010 00000001 F
S 80001014 FFFFFF20 F
S 80001018 07FFFFFF F
S 8000101C FFFFFFFF F
S 80001020 00000001 F
S 80001024 00000000 F
S 80001028 FFFFFFFC F
S 8000102C 80001064 F
S 80001030 80FF7F01 F
S 80001041 01010101 2
S 80001044 007F007F 3
S 80001040 FFFFFFFF 1
S 80001048 FFFFFF80 F
S 80001043 80808080 8
S 8000104C 000000FF F
S 80001042 80808080 4
S 80001046 7F017F01 C
S 80001050 FFFF80FF F
S 80001054 000080FF F
S 80001058 80FF7F01 F
S 80001060 00000005 F
S 80001064 00000005 F
S 80001068 00000005 F
S 8000106C 00000005 F
S 80001070 00000005 F
S 80001074 00000005 F
S 80001078 80000130 F
S 8000107C 80000140 F

// ==== flist.f ====
src/rv_pkg.sv
src/rv_ctrl_fsm.sv
src/rv_pc_counter.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_core_top.sv
dv/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
